//--- common/cache_pkg.sv
package cache_pkg;

    // byte address split as tag | set | offset
    localparam int addr_width  = 32;
    localparam int block_bytes = 8;
    localparam int offset_bits = $clog2(block_bytes);
    localparam int num_sets    = 64;
    localparam int set_bits    = $clog2(num_sets);
    localparam int tag_bits    = addr_width - set_bits - offset_bits;
    // lru is a single bit per set, so this stays at two
    localparam int num_ways    = 2;

    typedef logic [addr_width-1:0]    addr_t;
    typedef logic [set_bits-1:0]      set_t;
    typedef logic [tag_bits-1:0]      tag_t;
    // byte 0 sits in bits 7:0
    typedef logic [block_bytes*8-1:0] block_t;
    typedef logic [block_bytes-1:0]   byte_mask_t;

    // every byte enabled, used by block fills
    localparam byte_mask_t full_mask = '1;

    // field extraction helpers
    function automatic set_t get_set(addr_t a);
        return a[offset_bits +: set_bits];
    endfunction

    function automatic tag_t get_tag(addr_t a);
        return a[addr_width-1 -: tag_bits];
    endfunction

    function automatic logic [offset_bits-1:0] get_offset(addr_t a);
        return a[offset_bits-1:0];
    endfunction

endpackage

//--- cache/tag_array.sv
module tag_array (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rd,
    input  cache_pkg::addr_t addr,
    input  logic             wr,
    input  logic             wr_way,
    input  cache_pkg::tag_t  wr_tag,
    input  logic             touch,
    input  logic             touch_way,
    output logic             hit,
    output logic             hit_way,
    output logic             victim_way,
    output logic             victim_valid,
    output cache_pkg::tag_t  victim_tag
);
    import cache_pkg::*;

    // tag storage, read synchronously
    tag_t tag_mem [num_sets][num_ways];

    // control state per set
    logic [num_sets-1:0][num_ways-1:0] valid;
    // lru[s] names the least recently used way of set s
    logic [num_sets-1:0] lru;

    // registered read and registered lookup address
    tag_t [num_ways-1:0] tag_q;
    set_t set_q;
    tag_t req_tag_q;

    set_t cur_set;
    set_t victim_set;
    logic [num_ways-1:0] match;

    assign cur_set = get_set(addr);

    always_ff @(posedge clk) begin
        if (rd) begin
            for (int w = 0; w < num_ways; w++) begin
                tag_q[w] <= tag_mem[cur_set][w];
            end
            set_q     <= cur_set;
            req_tag_q <= get_tag(addr);
        end
        // fill lands on the request edge
        if (wr) begin
            tag_mem[cur_set][wr_way] <= wr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
            lru   <= '0;
        end else begin
            if (wr) begin
                valid[cur_set][wr_way] <= 1'b1;
                lru[cur_set]           <= ~wr_way;
            end
            // touch comes in the response cycle, so it uses the registered set
            if (touch) begin
                lru[set_q] <= ~touch_way;
            end
        end
    end

    // compare both ways, each qualified by its valid bit
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            match[w] = valid[set_q][w] && (tag_q[w] == req_tag_q);
        end
    end

    assign hit     = |match;
    // a set never holds the same tag twice
    assign hit_way = match[1];

    // a fill never shares a cycle with a response,
    // so during a fill the victim is taken for the fill's own set
    always_comb begin
        victim_set = wr ? cur_set : set_q;
        if (!valid[victim_set][0]) begin
            victim_way = 1'b0;
        end else if (!valid[victim_set][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru[victim_set];
        end
    end

    // victim details for the response cycle
    assign victim_valid = valid[set_q][victim_way];
    assign victim_tag   = tag_q[victim_way];

endmodule

//--- cache/data_array.sv
module data_array (
    input  logic                  clk,
    input  logic                  rd,
    input  cache_pkg::set_t       set,
    input  logic                  wr,
    input  logic                  wr_way,
    input  cache_pkg::byte_mask_t wr_mask,
    input  cache_pkg::set_t       wr_set,
    input  cache_pkg::block_t     wr_data,
    output cache_pkg::block_t     way0_data,
    output cache_pkg::block_t     way1_data
);
    import cache_pkg::*;

    // one block per set and way
    block_t mem [num_sets][num_ways];

    // both ways are read together, tag compare picks one later
    always_ff @(posedge clk) begin
        if (rd) begin
            way0_data <= mem[set][0];
            way1_data <= mem[set][1];
        end
    end

    // separate write set since a store writes one cycle after its read
    // read outputs keep the pre-write block until the next read
    always_ff @(posedge clk) begin
        if (wr) begin
            for (int b = 0; b < block_bytes; b++) begin
                // only masked bytes change
                if (wr_mask[b]) begin
                    mem[wr_set][wr_way][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- cache/icache.sv
module icache (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              lookup,
    input  logic              fill,
    input  cache_pkg::addr_t  addr,
    input  cache_pkg::block_t fill_data,
    output logic              resp,
    output logic              hit,
    output cache_pkg::block_t data
);
    import cache_pkg::*;

    logic   hit_way;
    logic   victim_way;
    set_t   cur_set;
    block_t way0_data;
    block_t way1_data;

    assign cur_set = get_set(addr);

    // tags, valid and lru
    // the victim tag is of no use here, nothing gets written back
    tag_array tag_array_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd           (lookup),
        .addr         (addr),
        .wr           (fill),
        .wr_way       (victim_way),
        .wr_tag       (get_tag(addr)),
        .touch        (resp & hit),
        .touch_way    (hit_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (),
        .victim_tag   ()
    );

    // fills write a whole block into the victim way
    data_array data_array_i (
        .clk       (clk),
        .rd        (lookup),
        .set       (cur_set),
        .wr        (fill),
        .wr_way    (victim_way),
        .wr_mask   (full_mask),
        .wr_set    (cur_set),
        .wr_data   (fill_data),
        .way0_data (way0_data),
        .way1_data (way1_data)
    );

    // response one cycle after the lookup
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp <= 1'b0;
        end else begin
            resp <= lookup;
        end
    end

    // hit way's block
    assign data = hit_way ? way1_data : way0_data;

endmodule

//--- cache/dcache.sv
module dcache (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              lookup,
    input  logic              store,
    input  logic              fill,
    input  cache_pkg::addr_t  addr,
    input  logic [7:0]        store_byte,
    input  cache_pkg::block_t fill_data,
    output logic              resp,
    output logic              hit,
    output cache_pkg::block_t data,
    output logic              victim_valid,
    output logic              victim_dirty,
    output cache_pkg::addr_t  victim_addr,
    output cache_pkg::block_t victim_data
);
    import cache_pkg::*;

    logic                   req;
    set_t                   cur_set;
    // registered request fields
    logic                   store_q;
    set_t                   set_q;
    logic [offset_bits-1:0] offset_q;
    logic [7:0]             byte_q;
    // tag array results
    logic                   hit_way;
    logic                   victim_way;
    logic                   tag_victim_valid;
    tag_t                   victim_tag;
    block_t                 way0_data;
    block_t                 way1_data;
    // dirty bit per set and way
    logic [num_sets-1:0][num_ways-1:0] dirty;
    logic                   store_hit;
    // data array write port
    logic                   arr_wr;
    logic                   arr_wr_way;
    byte_mask_t             arr_wr_mask;
    set_t                   arr_wr_set;
    block_t                 arr_wr_data;

    // a store reads like a lookup first
    assign req       = lookup | store;
    assign cur_set   = get_set(addr);
    assign store_hit = resp & store_q & hit;

    tag_array tag_array_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd           (req),
        .addr         (addr),
        .wr           (fill),
        .wr_way       (victim_way),
        .wr_tag       (get_tag(addr)),
        .touch        (resp & hit),
        .touch_way    (hit_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (tag_victim_valid),
        .victim_tag   (victim_tag)
    );

    data_array data_array_i (
        .clk       (clk),
        .rd        (req),
        .set       (cur_set),
        .wr        (arr_wr),
        .wr_way    (arr_wr_way),
        .wr_mask   (arr_wr_mask),
        .wr_set    (arr_wr_set),
        .wr_data   (arr_wr_data),
        .way0_data (way0_data),
        .way1_data (way1_data)
    );

    // fill takes the whole block now, a store hit writes one byte in its response cycle
    always_comb begin
        arr_wr      = fill | store_hit;
        arr_wr_way  = fill ? victim_way : hit_way;
        arr_wr_mask = fill ? full_mask : byte_mask_t'(1) << offset_q;
        arr_wr_set  = fill ? cur_set : set_q;
        arr_wr_data = fill ? fill_data : {block_bytes{byte_q}};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp    <= 1'b0;
            store_q <= 1'b0;
            dirty   <= '0;
        end else begin
            resp    <= req;
            store_q <= store;
            // a fresh line is clean
            if (fill) begin
                dirty[cur_set][victim_way] <= 1'b0;
            end
            if (store_hit) begin
                dirty[set_q][hit_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            set_q <= cur_set;
        end
        if (store) begin
            offset_q <= get_offset(addr);
            byte_q   <= store_byte;
        end
    end

    // block as read, before any store of this request
    assign data = hit_way ? way1_data : way0_data;

    // victim report, flags only raised on a miss
    assign victim_valid = ~hit & tag_victim_valid;
    assign victim_dirty = ~hit & dirty[set_q][victim_way];
    assign victim_addr  = {victim_tag, set_q, {offset_bits{1'b0}}};
    assign victim_data  = victim_way ? way1_data : way0_data;

endmodule

//--- hdl/cache_subsystem.sv
module cache_subsystem (
    input  logic              clk,
    input  logic              rst_n,
    // instruction side
    input  logic              ic_lookup,
    input  logic              ic_fill,
    input  cache_pkg::addr_t  ic_addr,
    input  cache_pkg::block_t ic_fill_data,
    output logic              ic_resp,
    output logic              ic_hit,
    output cache_pkg::block_t ic_data,
    // data side
    input  logic              dc_lookup,
    input  logic              dc_store,
    input  logic              dc_fill,
    input  cache_pkg::addr_t  dc_addr,
    input  logic [7:0]        dc_store_byte,
    input  cache_pkg::block_t dc_fill_data,
    output logic              dc_resp,
    output logic              dc_hit,
    output cache_pkg::block_t dc_data,
    output logic              dc_victim_valid,
    output logic              dc_victim_dirty,
    output cache_pkg::addr_t  dc_victim_addr,
    output cache_pkg::block_t dc_victim_data
);

    // the two caches share nothing but clock and reset
    icache icache_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .lookup    (ic_lookup),
        .fill      (ic_fill),
        .addr      (ic_addr),
        .fill_data (ic_fill_data),
        .resp      (ic_resp),
        .hit       (ic_hit),
        .data      (ic_data)
    );

    // write-back of victims is left to an outside controller
    dcache dcache_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup       (dc_lookup),
        .store        (dc_store),
        .fill         (dc_fill),
        .addr         (dc_addr),
        .store_byte   (dc_store_byte),
        .fill_data    (dc_fill_data),
        .resp         (dc_resp),
        .hit          (dc_hit),
        .data         (dc_data),
        .victim_valid (dc_victim_valid),
        .victim_dirty (dc_victim_dirty),
        .victim_addr  (dc_victim_addr),
        .victim_data  (dc_victim_data)
    );

endmodule

//--- testbench/cache_tb.sv
module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    // random requests, then a cycle limit sized from them with room for the directed phases
    localparam int num_random = 1100;
    localparam int max_cycles = 2 * (num_random + 100) + 1600;

    logic clk;
    logic rst_n;
    logic ic_lookup, ic_fill, ic_resp, ic_hit;
    addr_t ic_addr;
    block_t ic_fill_data, ic_data;
    logic dc_lookup, dc_store, dc_fill, dc_resp, dc_hit;
    logic dc_victim_valid, dc_victim_dirty;
    logic [7:0] dc_store_byte;
    addr_t dc_addr, dc_victim_addr;
    block_t dc_fill_data, dc_data, dc_victim_data;

    // reference model, index 0 is the instruction cache and 1 the data cache
    tag_t   tag_m   [2][num_sets][num_ways];
    logic   valid_m [2][num_sets][num_ways];
    logic   lru_m   [2][num_sets];
    block_t data_m  [2][num_sets][num_ways];
    logic   dirty_m [num_sets][num_ways];
    // predicted response fields
    logic   exp_hit [2];
    block_t exp_data [2];
    logic   exp_vvalid, exp_vdirty;
    addr_t  exp_vaddr;
    block_t exp_vdata;

    int ic_errors = 0;
    int dc_errors = 0;
    int strobe_errors = 0;
    int cycles = 0;
    logic [31:0] lfsr = 32'ha78f;

    cache_subsystem cache_subsystem_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic block_t rand_block();
        return {rand_bits(32), rand_bits(32)};
    endfunction

    // four tags over four sets keeps evictions frequent
    function automatic addr_t rand_addr();
        addr_t a;
        a = '0;
        a[10:9] = 2'(rand_bits(2));
        a[4:3] = 2'(rand_bits(2));
        a[2:0] = 3'(rand_bits(3));
        return a;
    endfunction

    function automatic logic present(input int c, input addr_t a);
        logic found;
        found = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid_m[c][a[8:3]][w] && tag_m[c][a[8:3]][w] == a[31:9]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // invalid way 0, then invalid way 1, then lru
    function automatic logic pick_victim(input int c, input set_t s);
        if (!valid_m[c][s][0]) begin
            return 1'b0;
        end
        if (!valid_m[c][s][1]) begin
            return 1'b1;
        end
        return lru_m[c][s];
    endfunction

    task automatic clear_model();
        for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < num_sets; s++) begin
                lru_m[c][s] = 1'b0;
                for (int w = 0; w < num_ways; w++) begin
                    valid_m[c][s][w] = 1'b0;
                    dirty_m[s][w] = 1'b0;
                end
            end
        end
    endtask

    // one sampled request, prediction for the response cycle that follows
    task automatic model_access(input int c, input logic rd, input logic st, input logic fl,
                                input addr_t a, input logic [7:0] sb, input block_t fd);
        set_t s;
        tag_t t;
        logic hit;
        logic way;
        logic vw;
        s = a[8:3];
        t = a[31:9];
        if (rd) begin
            hit = 1'b0;
            way = 1'b0;
            for (int w = 0; w < num_ways; w++) begin
                if (valid_m[c][s][w] && tag_m[c][s][w] == t) begin
                    hit = 1'b1;
                    way = (w == 1);
                end
            end
            vw = pick_victim(c, s);
            exp_hit[c] = hit;
            // block as it was before this store
            exp_data[c] = data_m[c][s][way];
            if (c == 1) begin
                exp_vvalid = !hit && valid_m[c][s][vw];
                exp_vdirty = !hit && dirty_m[s][vw];
                exp_vaddr = {tag_m[c][s][vw], s, 3'b000};
                exp_vdata = data_m[c][s][vw];
            end
            if (hit) begin
                lru_m[c][s] = !way;
                if (st) begin
                    data_m[c][s][way][int'(a[2:0]) * 8 +: 8] = sb;
                    dirty_m[s][way] = 1'b1;
                end
            end
        end
        if (fl) begin
            vw = pick_victim(c, s);
            tag_m[c][s][vw] = t;
            valid_m[c][s][vw] = 1'b1;
            data_m[c][s][vw] = fd;
            lru_m[c][s] = !vw;
            if (c == 1) begin
                dirty_m[s][vw] = 1'b0;
            end
        end
    endtask

    // inputs read here are the values the DUT samples on this edge
    always @(posedge clk) begin
        if (!rst_n) begin
            clear_model();
        end else begin
            model_access(0, ic_lookup, 1'b0, ic_fill, ic_addr, 8'h00, ic_fill_data);
            model_access(1, dc_lookup | dc_store, dc_store, dc_fill, dc_addr, dc_store_byte,
                         dc_fill_data);
        end
    end

    task automatic report_mismatch(input int c, input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        if (c == 0) begin
            ic_errors++;
        end else begin
            dc_errors++;
        end
        $display("error at %0t: %s expected %h, actual %h", $time, name, exp, act);
    endtask

    task automatic strobe_error(input string name);
        strobe_errors++;
        $display("%s did not follow its request by exactly one cycle at %0t", name, $time);
    endtask

    // strobe timing
    assert property (@(posedge clk) disable iff (!rst_n) ic_resp == $past(ic_lookup))
        else strobe_error("ic_resp");
    assert property (@(posedge clk) disable iff (!rst_n)
                     dc_resp == $past(dc_lookup || dc_store))
        else strobe_error("dc_resp");

    // instruction cache fields
    assert property (@(posedge clk) disable iff (!rst_n) ic_resp |-> ic_hit == exp_hit[0])
        else report_mismatch(0, "ic_hit", 64'($sampled(exp_hit[0])), 64'($sampled(ic_hit)));
    assert property (@(posedge clk) disable iff (!rst_n)
                     ic_resp && exp_hit[0] |-> ic_data == exp_data[0])
        else report_mismatch(0, "ic_data", $sampled(exp_data[0]), $sampled(ic_data));

    // data cache fields, victim address and data only matter for a valid victim
    assert property (@(posedge clk) disable iff (!rst_n) dc_resp |-> dc_hit == exp_hit[1])
        else report_mismatch(1, "dc_hit", 64'($sampled(exp_hit[1])), 64'($sampled(dc_hit)));
    assert property (@(posedge clk) disable iff (!rst_n)
                     dc_resp && exp_hit[1] |-> dc_data == exp_data[1])
        else report_mismatch(1, "dc_data", $sampled(exp_data[1]), $sampled(dc_data));
    assert property (@(posedge clk) disable iff (!rst_n)
                     dc_resp |-> dc_victim_valid == exp_vvalid)
        else report_mismatch(1, "dc_victim_valid", 64'($sampled(exp_vvalid)),
                             64'($sampled(dc_victim_valid)));
    assert property (@(posedge clk) disable iff (!rst_n)
                     dc_resp |-> dc_victim_dirty == exp_vdirty)
        else report_mismatch(1, "dc_victim_dirty", 64'($sampled(exp_vdirty)),
                             64'($sampled(dc_victim_dirty)));
    assert property (@(posedge clk) disable iff (!rst_n)
                     dc_resp && exp_vvalid |-> dc_victim_addr == exp_vaddr)
        else report_mismatch(1, "dc_victim_addr", 64'($sampled(exp_vaddr)),
                             64'($sampled(dc_victim_addr)));
    assert property (@(posedge clk) disable iff (!rst_n)
                     dc_resp && exp_vvalid |-> dc_victim_data == exp_vdata)
        else report_mismatch(1, "dc_victim_data", $sampled(exp_vdata),
                             $sampled(dc_victim_data));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // starts on an edge, leaves the following cycle idle, returns on an edge
    task automatic ic_req(input logic lk, input logic fl, input addr_t a, input block_t d);
        ic_lookup <= lk;
        ic_fill <= fl;
        ic_addr <= a;
        ic_fill_data <= d;
        @(posedge clk);
        ic_lookup <= 1'b0;
        ic_fill <= 1'b0;
        @(posedge clk);
    endtask

    task automatic dc_req(input logic lk, input logic st, input logic fl, input addr_t a,
                          input logic [7:0] b, input block_t d);
        dc_lookup <= lk;
        dc_store <= st;
        dc_fill <= fl;
        dc_addr <= a;
        dc_store_byte <= b;
        dc_fill_data <= d;
        @(posedge clk);
        dc_lookup <= 1'b0;
        dc_store <= 1'b0;
        dc_fill <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        addr_t a;
        logic [1:0] op;
        rst_n = 1'b0;
        ic_lookup = 1'b0;
        ic_fill = 1'b0;
        ic_addr = '0;
        ic_fill_data = '0;
        dc_lookup = 1'b0;
        dc_store = 1'b0;
        dc_fill = 1'b0;
        dc_addr = '0;
        dc_store_byte = '0;
        dc_fill_data = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        // cold caches miss everywhere
        ic_req(1'b1, 1'b0, 32'h0000_1000, '0);
        dc_req(1'b1, 1'b0, 1'b0, 32'h0000_2000, 8'h00, '0);
        dc_req(1'b1, 1'b0, 1'b0, 32'h0000_2248, 8'h00, '0);
        // fill then hit at two offsets, other tag in other set misses
        ic_req(1'b0, 1'b1, 32'h0000_0a18, rand_block());
        ic_req(1'b1, 1'b0, 32'h0000_0a18, '0);
        ic_req(1'b1, 1'b0, 32'h0000_0a1d, '0);
        ic_req(1'b1, 1'b0, 32'h0000_0c20, '0);
        // three tags in set 7, the hit on the first one leaves the second as lru
        ic_req(1'b0, 1'b1, 32'h0000_4238, rand_block());
        ic_req(1'b0, 1'b1, 32'h0000_4438, rand_block());
        ic_req(1'b1, 1'b0, 32'h0000_4238, '0);
        ic_req(1'b0, 1'b1, 32'h0000_4638, rand_block());
        ic_req(1'b1, 1'b0, 32'h0000_4438, '0);
        ic_req(1'b1, 1'b0, 32'h0000_4238, '0);
        ic_req(1'b1, 1'b0, 32'h0000_4638, '0);
        // store hit, then evict the dirty line through a miss
        dc_req(1'b0, 1'b0, 1'b1, 32'h0000_2248, 8'h00, rand_block());
        dc_req(1'b1, 1'b0, 1'b0, 32'h0000_2248, 8'h00, '0);
        dc_req(1'b0, 1'b1, 1'b0, 32'h0000_224b, 8'h5a, '0);
        dc_req(1'b1, 1'b0, 1'b0, 32'h0000_2248, 8'h00, '0);
        dc_req(1'b0, 1'b0, 1'b1, 32'h0000_2448, 8'h00, rand_block());
        dc_req(1'b1, 1'b0, 1'b0, 32'h0000_2448, 8'h00, '0);
        dc_req(1'b1, 1'b0, 1'b0, 32'h0000_2648, 8'h00, '0);
        // a store miss leaves the block alone
        dc_req(1'b0, 1'b1, 1'b0, 32'h0000_2649, 8'ha5, '0);
        dc_req(1'b1, 1'b0, 1'b0, 32'h0000_2248, 8'h00, '0);
        dc_req(1'b0, 1'b0, 1'b1, 32'h0000_2648, 8'h00, rand_block());
        dc_req(1'b1, 1'b0, 1'b0, 32'h0000_2248, 8'h00, '0);
        // mixed traffic, a fill is only sent for a block that is absent
        for (int i = 0; i < num_random; i++) begin
            a = rand_addr();
            op = 2'(rand_bits(2));
            if (rand_bits(1) == 32'd0) begin
                if (op == 2'd0 && !present(0, a)) begin
                    ic_req(1'b0, 1'b1, a, rand_block());
                end else begin
                    ic_req(1'b1, 1'b0, a, '0);
                end
            end else if (op == 2'd0 && !present(1, a)) begin
                dc_req(1'b0, 1'b0, 1'b1, a, 8'h00, rand_block());
            end else if (op == 2'd1) begin
                dc_req(1'b0, 1'b1, 1'b0, a, 8'(rand_bits(8)), '0);
            end else begin
                dc_req(1'b1, 1'b0, 1'b0, a, 8'h00, '0);
            end
        end
        repeat (3) @(posedge clk);
        $display("errors: ic %0d, dc %0d, strobe %0d", ic_errors, dc_errors, strobe_errors);
        if (ic_errors + dc_errors + strobe_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sources.f
common/cache_pkg.sv
cache/tag_array.sv
cache/data_array.sv
cache/icache.sv
cache/dcache.sv
hdl/cache_subsystem.sv
testbench/cache_tb.sv
